//--- logic/machine_defines.svh
// Sizes of the machine's memories and fields
// Include wherever a depth or width is needed

`ifndef MACHINE_DEFINES_SVH
`define MACHINE_DEFINES_SVH

`define WORD_WIDTH         16                           // Data word
`define INSTRUCTION_WIDTH  256                          // One code slot

`define CODE_DEPTH         16                           // Code slots
`define CODE_INDEX_WIDTH   4                            // Addresses a code slot
`define CODE_COUNT_WIDTH   5                            // Holds 0 to CODE_DEPTH
`define IP_WIDTH           16                           // Instruction pointer, wraps when negative

`define LOCAL_DEPTH        8                            // Local words
`define LOCAL_INDEX_WIDTH  3

`define HEAP_AREA          4                            // Words per heap area
`define HEAP_AREAS         4                            // Number of areas
`define HEAP_DEPTH         (`HEAP_AREA * `HEAP_AREAS)
`define HEAP_INDEX_WIDTH   4

`endif

//--- logic/isaPkg.sv
// Instruction set of the machine
// Opcodes keep the numbering of the original instruction list

`include "machine_defines.svh"

package isaPkg;

  // --------------------
  // Opcodes
  typedef enum logic [31:0] {
    opAdd        = 32'd0,
    opJEq        = 32'd22,
    opJFalse     = 32'd23,
    opJGe        = 32'd24,
    opJGt        = 32'd25,
    opJLe        = 32'd26,
    opJLt        = 32'd27,
    opJNe        = 32'd28,
    opJTrue      = 32'd29,
    opJmp        = 32'd30,
    opMov        = 32'd34,
    opNop        = 32'd36,
    opNot        = 32'd37,
    opOut        = 32'd38,
    opShiftLeft  = 32'd53,
    opShiftRight = 32'd54,
    opSubtract   = 32'd56
  } opcodeT;                                            // Others run as nop

  typedef enum logic [1:0] {
    arenaNone  = 2'd0,
    arenaHeap  = 2'd1,
    arenaLocal = 2'd2
  } arenaT;

  // --------------------
  // Operand descriptor, 64 bits
  typedef struct packed {
    logic [31:0] area;                                  // Heap area or jump offset
    logic [15:0] address;
    logic [1:0]  spare;
    arenaT       arena;
    logic [1:0]  dArea;                                 // 1 reads area from local
    logic [1:0]  dAddress;                              // 0 immediate, 1 direct, 2 via local
    logic [7:0]  delta;
  } operandT;

  // Spare field pads the format out to the full slot
  typedef struct packed {
    opcodeT  opcode;
    logic [`INSTRUCTION_WIDTH-$bits(opcodeT)-3*$bits(operandT)-1:0] spare;
    operandT target;
    operandT source1;
    operandT source2;
  } instructionT;

endpackage

//--- logic/machinePkg.sv
// Data path and control types shared by the machine's units

`include "machine_defines.svh"

package machinePkg;

  typedef logic signed [`WORD_WIDTH-1:0] wordT;

  // Operand values resolved for one instruction
  typedef struct packed {
    wordT targetValue;
    wordT source1Value;
    wordT source2Value;
  } operandValuesT;

  // Result headed for the target location
  typedef struct packed {
    logic enable;
    wordT data;
  } writeBackT;

  // One word on the output channel
  typedef struct packed {
    logic valid;                                        // Single cycle pulse
    wordT value;
  } outputT;

  // --------------------
  // Sequencer states
  typedef enum logic [1:0] {
    stateIdle,                                          // Waiting for run
    stateRunning,
    stateDone                                           // Ip left the program
  } runStateT;

endpackage

//--- logic/codeMemory.sv
// Code store written through a load port while the machine is stopped
// Presents the instruction at ip without a clock delay

`include "machine_defines.svh"

module codeMemory
  import isaPkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          loadEnable,
  input  logic [`CODE_INDEX_WIDTH-1:0]  loadAddress,
  input  instructionT                   loadInstruction,
  input  logic [`IP_WIDTH-1:0]          ip,
  output instructionT                   instruction,
  output logic [`CODE_COUNT_WIDTH-1:0]  programLength
);

  instructionT                  code [`CODE_DEPTH];
  logic [`CODE_COUNT_WIDTH-1:0] loadEnd;

  assign loadEnd = `CODE_COUNT_WIDTH'(loadAddress) + 1'b1;   // One past the slot being loaded

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CODE_DEPTH; i++) begin
        code[i] <= '0;
      end
      programLength <= '0;
    end else if (loadEnable) begin
      code[loadAddress] <= loadInstruction;
      if (loadEnd > programLength) begin                // Track highest slot loaded
        programLength <= loadEnd;
      end
    end
  end

  always_comb begin
    if (ip < `IP_WIDTH'(`CODE_DEPTH)) begin
      instruction = code[ip[`CODE_INDEX_WIDTH-1:0]];
    end else begin
      instruction        = '0;                          // Past the store, run a nop
      instruction.opcode = opNop;
    end
  end

endmodule

//--- logic/operandStore.sv
// Local and heap memories of the machine
// Resolves the target and both sources of the current instruction and
// commits the execute unit's result to the target on the clock edge

`include "machine_defines.svh"

module operandStore
  import isaPkg::*;
  import machinePkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          run,
  input  operandT       target,
  input  operandT       source1,
  input  operandT       source2,
  input  writeBackT     writeBack,
  output operandValuesT values
);

  wordT localMem [`LOCAL_DEPTH];
  wordT heapMem  [`HEAP_DEPTH];

  logic                          targetWritable;
  logic [`LOCAL_INDEX_WIDTH-1:0] targetLocalIndex;
  logic [`HEAP_INDEX_WIDTH-1:0]  targetHeapIndex;

  // --------------------
  // Addressing helpers

  // Local word at a wrapped index, zero extended for address arithmetic
  function automatic logic [31:0] localIndirect(input logic [31:0] index);
    logic [31:0] wrapped;
    wrapped = index % `LOCAL_DEPTH;
    return {{(32-`WORD_WIDTH){1'b0}}, localMem[wrapped[`LOCAL_INDEX_WIDTH-1:0]]};
  endfunction

  function automatic logic [`LOCAL_INDEX_WIDTH-1:0] localIndex(input operandT op);
    logic [31:0] offset;
    logic [31:0] wrapped;
    offset  = op.dAddress == 2'd2 ? localIndirect(32'(op.address)) : 32'(op.address);
    wrapped = (32'(op.delta) + offset) % `LOCAL_DEPTH;
    return wrapped[`LOCAL_INDEX_WIDTH-1:0];
  endfunction

  function automatic logic [`HEAP_INDEX_WIDTH-1:0] heapIndex(input operandT op);
    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] wrapped;
    base    = op.dArea == 2'd1 ? localIndirect(op.area) : op.area;   // Area number
    offset  = op.dAddress == 2'd2 ? localIndirect(32'(op.address)) : 32'(op.address);
    wrapped = (32'(op.delta) + base * `HEAP_AREA + offset) % `HEAP_DEPTH;
    return wrapped[`HEAP_INDEX_WIDTH-1:0];
  endfunction

  // Descriptor names a memory location rather than an immediate
  function automatic logic addressable(input operandT op);
    logic direct;
    direct = op.dAddress == 2'd1 || op.dAddress == 2'd2;
    case (op.arena)
      arenaLocal: return direct;
      arenaHeap:  return direct && (op.dArea == 2'd0 || op.dArea == 2'd1);
      default:    return 1'b0;
    endcase
  endfunction

  function automatic wordT operandValue(input operandT op);
    wordT value;
    value = '0;                                         // Arena none and bad modes
    if (op.arena != arenaNone && op.dAddress == 2'd0) begin
      value = wordT'(op.address);                       // Immediate
    end else if (addressable(op)) begin
      if (op.arena == arenaLocal) begin
        value = localMem[localIndex(op)];
      end else begin
        value = heapMem[heapIndex(op)];
      end
    end
    return value;
  endfunction

  // --------------------
  // Operand resolution

  always_comb begin
    values.targetValue  = operandValue(target);
    values.source1Value = operandValue(source1);
    values.source2Value = operandValue(source2);
    targetWritable      = addressable(target);
    targetLocalIndex    = localIndex(target);
    targetHeapIndex     = heapIndex(target);
  end

  // --------------------
  // Target write, memories cleared whenever the machine is stopped

  always_ff @(posedge clock) begin
    if (reset || !run) begin
      for (int i = 0; i < `LOCAL_DEPTH; i++) begin
        localMem[i] <= '0;
      end
      for (int i = 0; i < `HEAP_DEPTH; i++) begin
        heapMem[i] <= '0;
      end
    end else if (writeBack.enable && targetWritable) begin
      if (target.arena == arenaLocal) begin
        localMem[targetLocalIndex] <= writeBack.data;
      end else begin
        heapMem[targetHeapIndex] <= writeBack.data;
      end
    end
  end

endmodule

//--- logic/executeUnit.sv
// Decodes the current instruction and computes its result
// Drives the target write, the branch request and the output strobe

`include "machine_defines.svh"

module executeUnit
  import isaPkg::*;
  import machinePkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          executing,
  input  instructionT   instruction,
  input  operandValuesT values,
  output writeBackT     writeBack,
  output logic          branchTaken,
  output wordT          branchOffset,
  output outputT        out
);

  wordT result;
  logic writes;                                         // Opcode stores to target
  logic jump;                                           // Jump condition holds
  logic outValid;
  wordT outValue;
  wordT s1;
  wordT s2;

  assign s1 = values.source1Value;
  assign s2 = values.source2Value;

  // --------------------
  // Decode
  always_comb begin
    result = '0;
    writes = 1'b0;
    jump   = 1'b0;
    case (instruction.opcode)
      opAdd: begin
        result = s1 + s2;
        writes = 1'b1;
      end
      opSubtract: begin
        result = s1 - s2;
        writes = 1'b1;
      end
      opMov: begin
        result = s1;
        writes = 1'b1;
      end
      opNot: begin
        result = s1 == '0 ? wordT'(1) : '0;
        writes = 1'b1;
      end
      opShiftLeft: begin
        result = wordT'($unsigned(values.targetValue) << $unsigned(s1));
        writes = 1'b1;
      end
      opShiftRight: begin
        result = wordT'($unsigned(values.targetValue) >> $unsigned(s1));   // Logical
        writes = 1'b1;
      end
      opJEq:    jump = s1 == s2;
      opJNe:    jump = s1 != s2;
      opJLt:    jump = s1 < s2;                         // Signed compares
      opJLe:    jump = s1 <= s2;
      opJGt:    jump = s1 > s2;
      opJGe:    jump = s1 >= s2;
      opJTrue:  jump = s1 != '0;
      opJFalse: jump = s1 == '0;
      opJmp:    jump = 1'b1;
      default:  ;                                       // Nop and unsupported opcodes
    endcase
  end

  assign writeBack.enable = executing && writes;
  assign writeBack.data   = result;
  assign branchTaken      = executing && jump;
  assign branchOffset     = instruction.target.area[`WORD_WIDTH-1:0];   // Relative to ip

  // --------------------
  // Output strobe, one cycle after the out instruction
  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
    end else begin
      outValid <= executing && instruction.opcode == opOut;
    end
  end

  always_ff @(posedge clock) begin
    outValue <= s1;
  end

  assign out.valid = outValid;
  assign out.value = outValue;

endmodule

//--- logic/sequencer.sv
// Instruction pointer and run control
// Steps through the program while run is high and flags the finish

`include "machine_defines.svh"

module sequencer
  import machinePkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic [`CODE_COUNT_WIDTH-1:0]  programLength,
  input  logic                          branchTaken,
  input  wordT                          branchOffset,
  output logic [`IP_WIDTH-1:0]          ip,
  output logic                          executing,
  output logic                          finished
);

  runStateT state;
  logic     inRange;

  assign inRange   = ip < `IP_WIDTH'(programLength);   // Negative ip wraps high
  assign executing = run && state == stateRunning && inRange;
  assign finished  = state == stateDone;

  always_ff @(posedge clock) begin
    if (reset || !run) begin
      state <= stateIdle;
      ip    <= '0;
    end else begin
      case (state)
        stateIdle: state <= stateRunning;
        stateRunning: begin
          if (!inRange) begin
            state <= stateDone;                         // Ip left the program
          end else if (branchTaken) begin
            ip <= ip + `IP_WIDTH'(branchOffset);
          end else begin
            ip <= ip + 1'b1;
          end
        end
        stateDone: state <= stateDone;                  // Hold until run drops
        default:   state <= stateIdle;
      endcase
    end
  end

endmodule

//--- logic/nwayMachine.sv
// Top level of the register-transfer machine
// Load code while run is low, then raise run and wait for finished

`include "machine_defines.svh"

module nwayMachine
  import isaPkg::*;
  import machinePkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          loadEnable,
  input  logic [`CODE_INDEX_WIDTH-1:0]  loadAddress,
  input  instructionT                   loadInstruction,
  output logic                          finished,
  output outputT                        out
);

  logic [`IP_WIDTH-1:0]         ip;
  logic [`CODE_COUNT_WIDTH-1:0] programLength;
  instructionT                  instruction;
  operandValuesT                values;
  writeBackT                    writeBack;
  logic                         branchTaken;
  wordT                         branchOffset;
  logic                         executing;

  codeMemory codeMemory (
    .clock          (clock),
    .reset          (reset),
    .loadEnable     (loadEnable),
    .loadAddress    (loadAddress),
    .loadInstruction(loadInstruction),
    .ip             (ip),
    .instruction    (instruction),
    .programLength  (programLength)
  );

  operandStore operandStore (
    .clock    (clock),
    .reset    (reset),
    .run      (run),
    .target   (instruction.target),
    .source1  (instruction.source1),
    .source2  (instruction.source2),
    .writeBack(writeBack),
    .values   (values)
  );

  executeUnit executeUnit (
    .clock       (clock),
    .reset       (reset),
    .executing   (executing),
    .instruction (instruction),
    .values      (values),
    .writeBack   (writeBack),
    .branchTaken (branchTaken),
    .branchOffset(branchOffset),
    .out         (out)
  );

  sequencer sequencer (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .programLength(programLength),
    .branchTaken  (branchTaken),
    .branchOffset (branchOffset),
    .ip           (ip),
    .executing    (executing),
    .finished     (finished)
  );

endmodule

//--- testbench/nwayMachine_assert.sv
// Concurrent checks on the machine's run control and output strobe
// Bound into every nwayMachine instance

module nwayMachineAssert
  import machinePkg::*;
(
  input logic   clock,
  input logic   reset,
  input logic   run,
  input logic   loadEnable,
  input logic   finished,
  input outputT out
);
  timeunit 1ns;
  timeprecision 100ps;

  finishedLowAfterReset: assert property (@(posedge clock) reset |=> !finished)
    else $error("finished is high on the cycle after reset");

  // No output once the program has been left
  noOutAfterFinish: assert property (@(posedge clock) disable iff (reset)
    finished |=> !out.valid)
    else $error("out.valid pulsed after finished was already high");

  loadOnlyWhenStopped: assert property (@(posedge clock) disable iff (reset)
    loadEnable |-> !run)
    else $error("loadEnable is high while run is high");

  finishedHolds: assert property (@(posedge clock) disable iff (reset)
    finished && run |=> finished)
    else $error("finished dropped while run stayed high");

endmodule

bind nwayMachine nwayMachineAssert checks (
  .clock     (clock),
  .reset     (reset),
  .run       (run),
  .loadEnable(loadEnable),
  .finished  (finished),
  .out       (out)
);

//--- testbench/nwayMachineTb.sv
// Testbench for the machine running directed and LFSR-generated programs on the DUT
// Expected outputs come from a reference interpreter of the loaded code image

`include "machine_defines.svh"

module nwayMachineTb
  import isaPkg::*;
  import machinePkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 8;
  localparam int RANDOM_PROGRAMS = 20;
  localparam int TEST_COUNT = 9 + RANDOM_PROGRAMS;    // Directed programs first
  localparam int WATCHDOG_CYCLES = TEST_COUNT * (2 * `CODE_DEPTH + 20) + 4;

  logic                         clock = 1'b0;
  logic                         reset;
  logic                         run;
  logic                         loadEnable;
  logic [`CODE_INDEX_WIDTH-1:0] loadAddress;
  instructionT                  loadInstruction;
  logic                         finished;
  outputT                       out;

  instructionT codeImage [`CODE_DEPTH];                // Mirror of the code store
  int          progLen;
  instructionT progQ [$];
  wordT        refLocal [`LOCAL_DEPTH];
  wordT        refHeap [`HEAP_DEPTH];
  wordT        expected [$];
  int          expectedCount;
  int          seenCount;
  logic        runDone;
  logic [31:0] lfsr;

  opcodeT      jumpOps [9] = '{opJEq, opJNe, opJLt, opJLe, opJGt, opJGe, opJTrue, opJFalse, opJmp};
  opcodeT      randomOps [16] = '{opAdd, opSubtract, opMov, opNot, opShiftLeft, opShiftRight,
                                  opOut, opOut, opJEq, opJNe, opJLt, opJGe, opJTrue, opJFalse,
                                  opJmp, opNop};
  logic [15:0] pairA [4] = '{16'd3, 16'd5, 16'd4, 16'd0};
  logic [15:0] pairB [4] = '{16'd5, 16'd3, 16'd4, 16'hfffe};   // Last pair is signed

  nwayMachine dut (
    .clock          (clock),
    .reset          (reset),
    .run            (run),
    .loadEnable     (loadEnable),
    .loadAddress    (loadAddress),
    .loadInstruction(loadInstruction),
    .finished       (finished),
    .out            (out)
  );

  always #(PERIOD / 2) clock = ~clock;

  // --------------------
  // Failure reporting and checks
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkOutValue(input wordT actual, input wordT expectedValue);
    if (actual !== expectedValue) begin
      abortRun($sformatf("Error: out.value is %h, expected %h", actual, expectedValue));
    end
  endtask

  task automatic checkOutCount(input logic [`CODE_COUNT_WIDTH-1:0] actual,
                               input logic [`CODE_COUNT_WIDTH-1:0] expectedTotal);
    if (actual !== expectedTotal) begin
      abortRun($sformatf("Error: out.valid count is %h, expected %h", actual, expectedTotal));
    end
  endtask

  // --------------------
  // Random numbers from a Galois LFSR
  function automatic logic randomBit();
    logic bitOut;
    bitOut = lfsr[0];
    lfsr   = lfsr >> 1;
    if (bitOut) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return bitOut;
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], randomBit()};
    end
    return value;
  endfunction

  // --------------------
  // Instruction builders
  function automatic operandT makeOperand(input arenaT arena, input logic [1:0] dArea,
                                          input logic [1:0] dAddress, input logic [31:0] area,
                                          input logic [15:0] address, input logic [7:0] delta);
    operandT op;
    op          = '0;
    op.arena    = arena;
    op.dArea    = dArea;
    op.dAddress = dAddress;
    op.area     = area;
    op.address  = address;
    op.delta    = delta;
    return op;
  endfunction

  function automatic operandT immediate(input logic [15:0] value);
    return makeOperand(arenaLocal, 2'd0, 2'd0, 32'd0, value, 8'd0);
  endfunction

  function automatic operandT localAt(input logic [15:0] address);
    return makeOperand(arenaLocal, 2'd0, 2'd1, 32'd0, address, 8'd0);
  endfunction

  function automatic operandT heapAt(input logic [1:0] dArea, input logic [1:0] dAddress,
                                     input logic [31:0] area, input logic [15:0] address,
                                     input logic [7:0] delta);
    return makeOperand(arenaHeap, dArea, dAddress, area, address, delta);
  endfunction

  function automatic instructionT makeInstr(input opcodeT opcode, input operandT target,
                                            input operandT source1, input operandT source2);
    instructionT ins;
    ins         = '0;
    ins.opcode  = opcode;
    ins.target  = target;
    ins.source1 = source1;
    ins.source2 = source2;
    return ins;
  endfunction

  function automatic operandT randomOperand();
    operandT op;
    op          = '0;
    op.arena    = arenaT'(randomBits(2) % 3);
    op.dArea    = 2'(randomBits(1));
    op.dAddress = 2'(randomBits(2) % 3);
    op.area     = randomBits(3);
    op.address  = 16'(randomBits(16));
    op.delta    = 8'(randomBits(3));
    return op;
  endfunction

  function automatic instructionT randomInstr();
    opcodeT  opcode;
    operandT target;
    operandT source1;
    operandT source2;
    opcode  = randomOps[randomBits(4)];
    target  = randomOperand();
    source1 = randomOperand();
    source2 = randomOperand();
    if (opcode >= opJEq && opcode <= opJmp) begin
      target.area = 32'd1 + randomBits(2);              // Forward jumps only
    end
    return makeInstr(opcode, target, source1, source2);
  endfunction

  // --------------------
  // Reference model
  function automatic logic [31:0] localWord(input logic [31:0] index);
    return {{(32 - `WORD_WIDTH){1'b0}}, refLocal[index % `LOCAL_DEPTH]};
  endfunction

  // Memory slot named by a descriptor or 0 when it names none
  function automatic bit locate(input operandT op, output bit inHeap, output int index);
    logic [31:0] offset;
    logic [31:0] base;
    inHeap = op.arena == arenaHeap;
    index  = 0;
    if (op.dAddress != 2'd1 && op.dAddress != 2'd2) return 1'b0;
    offset = op.dAddress == 2'd2 ? localWord(32'(op.address)) : 32'(op.address);
    if (op.arena == arenaLocal) begin
      index = int'((32'(op.delta) + offset) % `LOCAL_DEPTH);
      return 1'b1;
    end
    if (op.arena != arenaHeap || op.dArea > 2'd1) return 1'b0;
    base  = op.dArea == 2'd1 ? localWord(op.area) : op.area;
    index = int'((32'(op.delta) + base * `HEAP_AREA + offset) % `HEAP_DEPTH);
    return 1'b1;
  endfunction

  function automatic wordT refValue(input operandT op);
    bit inHeap;
    int index;
    if (op.arena == arenaNone) return '0;
    if (op.dAddress == 2'd0) return wordT'(op.address);
    if (!locate(op, inHeap, index)) return '0;
    return inHeap ? refHeap[index] : refLocal[index];
  endfunction

  // Runs the code image from cleared memories and returns the output count
  function automatic int refRun();
    logic [`IP_WIDTH-1:0] ip;
    instructionT          ins;
    wordT                 t;
    wordT                 s1;
    wordT                 s2;
    wordT                 result;
    bit                   writes;
    bit                   jump;
    bit                   inHeap;
    int                   index;
    int                   steps;
    refLocal = '{default: '0};
    refHeap  = '{default: '0};
    expected.delete();
    ip    = '0;
    steps = 0;
    while (ip < progLen && steps < 4 * `CODE_DEPTH) begin
      ins    = codeImage[ip];
      t      = refValue(ins.target);
      s1     = refValue(ins.source1);
      s2     = refValue(ins.source2);
      result = '0;
      writes = 1'b1;
      jump   = 1'b0;
      case (ins.opcode)
        opAdd:        result = s1 + s2;
        opSubtract:   result = s1 - s2;
        opMov:        result = s1;
        opNot:        result = s1 == 0 ? 16'sd1 : 16'sd0;
        opShiftLeft:  result = $unsigned(t) << $unsigned(s1);
        opShiftRight: result = $unsigned(t) >> $unsigned(s1);
        default:      writes = 1'b0;
      endcase
      case (ins.opcode)
        opJEq:    jump = s1 == s2;
        opJNe:    jump = s1 != s2;
        opJLt:    jump = s1 < s2;
        opJLe:    jump = s1 <= s2;
        opJGt:    jump = s1 > s2;
        opJGe:    jump = s1 >= s2;
        opJTrue:  jump = s1 != 0;
        opJFalse: jump = s1 == 0;
        opJmp:    jump = 1'b1;
        opOut:    expected.push_back(s1);
        default:  ;
      endcase
      if (writes && locate(ins.target, inHeap, index)) begin
        if (inHeap) refHeap[index] = result;
        else refLocal[index] = result;
      end
      ip    = jump ? ip + ins.target.area[`IP_WIDTH-1:0] : ip + 1'b1;
      steps = steps + 1;
    end
    return expected.size();
  endfunction

  // --------------------
  // Loading and running
  task automatic loadSlot(input int slot, input instructionT ins);
    loadEnable      = 1'b1;
    loadAddress     = `CODE_INDEX_WIDTH'(slot);
    loadInstruction = ins;
    @(negedge clock);
    loadEnable      = 1'b0;
    codeImage[slot] = ins;
    if (slot + 1 > progLen) progLen = slot + 1;        // Length never shrinks
  endtask

  task automatic runTest();
    for (int i = 0; i < progQ.size(); i++) begin
      loadSlot(i, progQ[i]);
    end
    expectedCount = refRun();
    seenCount     = 0;
    runDone       = 1'b0;
    run           = 1'b1;
    wait (runDone);
    @(negedge clock);
    run = 1'b0;
    @(negedge clock);                                   // Idle with memories cleared
    progQ.delete();
  endtask

  // Compare process samples at the falling edge where outputs are stable
  always @(negedge clock) begin
    if (!reset && run && !runDone) begin
      if (out.valid) begin
        if (expected.size() == 0) begin
          abortRun("The DUT produced more outputs than the program should give");
        end else begin
          checkOutValue(out.value, expected.pop_front());
          seenCount = seenCount + 1;
        end
      end
      if (finished) begin
        checkOutCount(`CODE_COUNT_WIDTH'(seenCount), `CODE_COUNT_WIDTH'(expectedCount));
        runDone = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    abortRun("Timeout: the machine did not finish its programs in time");
  end

  // --------------------
  // Stimulus
  initial begin
    int length;
    lfsr            = 32'h6777;
    reset           = 1'b1;
    run             = 1'b0;
    loadEnable      = 1'b0;
    loadAddress     = '0;
    loadInstruction = '0;
    runDone         = 1'b1;
    progLen         = 0;
    codeImage       = '{default: '0};
    repeat (4) @(negedge clock);
    reset = 1'b0;

    // Immediate, direct and indirect local operands
    progQ.push_back(makeInstr(opMov, localAt(0), immediate(16'd7), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(0), '0));
    progQ.push_back(makeInstr(opAdd, localAt(1), localAt(0), immediate(16'd5)));
    progQ.push_back(makeInstr(opOut, '0, localAt(1), '0));
    progQ.push_back(makeInstr(opSubtract, localAt(2), localAt(1), immediate(16'd20)));
    progQ.push_back(makeInstr(opOut, '0, localAt(2), '0));
    progQ.push_back(makeInstr(opNot, localAt(3), localAt(2), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(3), '0));
    progQ.push_back(makeInstr(opNot, makeOperand(arenaLocal, 2'd0, 2'd2, 0, 0, 0), localAt(5), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(7), '0));
    runTest();

    // Heap with every dArea and dAddress pairing
    progQ.push_back(makeInstr(opMov, localAt(0), immediate(16'd2), '0));
    progQ.push_back(makeInstr(opMov, localAt(1), immediate(16'd3), '0));
    progQ.push_back(makeInstr(opMov, heapAt(2'd0, 2'd1, 1, 2, 0), immediate(16'd11), '0));
    progQ.push_back(makeInstr(opMov, heapAt(2'd0, 2'd2, 3, 1, 0), immediate(16'd12), '0));
    progQ.push_back(makeInstr(opMov, heapAt(2'd1, 2'd1, 0, 1, 0), immediate(16'd13), '0));
    progQ.push_back(makeInstr(opMov, heapAt(2'd1, 2'd2, 0, 1, 1), immediate(16'd14), '0));
    progQ.push_back(makeInstr(opOut, '0, heapAt(2'd0, 2'd1, 1, 2, 0), '0));
    progQ.push_back(makeInstr(opOut, '0, heapAt(2'd0, 2'd2, 3, 1, 0), '0));
    progQ.push_back(makeInstr(opOut, '0, heapAt(2'd1, 2'd1, 0, 1, 0), '0));
    progQ.push_back(makeInstr(opOut, '0, heapAt(2'd1, 2'd2, 0, 1, 1), '0));
    runTest();

    // Shifts work on the target's prior value
    progQ.push_back(makeInstr(opMov, localAt(2), immediate(16'h8181), '0));
    progQ.push_back(makeInstr(opShiftRight, localAt(2), immediate(16'd4), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(2), '0));
    progQ.push_back(makeInstr(opShiftLeft, localAt(2), immediate(16'd3), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(2), '0));
    progQ.push_back(makeInstr(opShiftLeft, localAt(2), immediate(16'd17), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(2), '0));
    runTest();

    // Each jump skips a marked out and the operand pairs give both outcomes
    for (int j = 0; j < 9; j++) begin
      for (int p = 0; p < 4; p++) begin
        progQ.push_back(makeInstr(jumpOps[j], makeOperand(arenaNone, 2'd0, 2'd0, 2, 0, 0),
                                  immediate(pairA[p]), immediate(pairB[p])));
        progQ.push_back(makeInstr(opOut, '0, immediate(16'(4 * j + p)), '0));
        if (progQ.size() == `CODE_DEPTH) runTest();
      end
    end
    if (progQ.size() != 0) runTest();

    // Unsupported opcodes behave as nop
    progQ.push_back(makeInstr(opMov, heapAt(2'd0, 2'd1, 2, 1, 0), immediate(16'd21), '0));
    progQ.push_back(makeInstr(opMov, localAt(0), immediate(16'd9), '0));
    progQ.push_back(makeInstr(opcodeT'(32'd1), heapAt(2'd0, 2'd1, 2, 1, 0), immediate(5), '0));
    progQ.push_back(makeInstr(opcodeT'(32'd60), localAt(0), immediate(16'd5), '0));
    progQ.push_back(makeInstr(opNop, localAt(0), immediate(16'd6), '0));
    progQ.push_back(makeInstr(opOut, '0, heapAt(2'd0, 2'd1, 2, 1, 0), '0));
    progQ.push_back(makeInstr(opOut, '0, localAt(0), '0));
    runTest();

    repeat (RANDOM_PROGRAMS) begin
      length = 1 + int'(randomBits(4));
      for (int i = 0; i < length; i++) begin
        progQ.push_back(randomInstr());
      end
      runTest();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+logic
logic/isaPkg.sv
logic/machinePkg.sv
logic/codeMemory.sv
logic/operandStore.sv
logic/executeUnit.sv
logic/sequencer.sv
logic/nwayMachine.sv
testbench/nwayMachine_assert.sv
testbench/nwayMachineTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the machine testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module nwayMachineTb -f sim.f -o simMachine

output=$(./obj_dir/simMachine) || true
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
  exit 0
fi
exit 1
